//--- task_injector.f
+incdir+design
design/injector_pkg.sv
design/packet_receiver.sv
design/packet_sender.sv
design/injector_ctrl.sv
design/task_injector.sv
tests/tb_task_injector.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the task injector testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f task_injector.f \
    --top-module tb_task_injector \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tests/tb_task_injector.sv
`timescale 1ns/100ps
`include "injector_cfg.svh"

module tb_task_injector;

    localparam int unsigned max_cycles = 20000;
    localparam int unsigned hdr_words  = `INJ_HEADER_SIZE;

    logic                clk_i;
    logic                rst_ni;
    logic                src_rx_i;
    injector_pkg::flit_t src_data_i;
    logic                src_credit_o;
    logic                noc_tx_o;
    logic                noc_credit_i;
    injector_pkg::flit_t noc_data_o;
    logic                noc_rx_i;
    logic                noc_credit_o;
    injector_pkg::flit_t noc_data_i;

    injector_pkg::flit_t       src_q[$];     // words offered on the source port.
    injector_pkg::flit_t       noc_in_q[$];  // flits from the mapper model.
    injector_pkg::flit_t       out_q[$];     // flits collected from the DUT.
    injector_pkg::flit_t       ref_q[$];
    injector_pkg::flit_t       pld_q[$];
    injector_pkg::task_sizes_t task_sizes[4];
    injector_pkg::flit_t       task_target[4];
    logic [31:0]               lcg_state;
    logic                      stress_en;  // random back-pressure and source gaps.
    int unsigned               cycle_cnt;
    int unsigned               err_cnt;
    int unsigned               test_cnt;

    task_injector DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .src_credit_o (src_credit_o),
        .noc_tx_o     (noc_tx_o),
        .noc_credit_i (noc_credit_i),
        .noc_data_o   (noc_data_o),
        .noc_rx_i     (noc_rx_i),
        .noc_credit_o (noc_credit_o),
        .noc_data_i   (noc_data_i)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic injector_pkg::flit_t code_len(input int n);
        return (task_sizes[n].text_size + task_sizes[n].data_size) / 4;
    endfunction

    function automatic injector_pkg::flit_t code_word(input injector_pkg::flit_t app_id,
                                                      input int n, input int k);
        return {8'hc0, app_id[7:0], 8'(n), 8'(k)};
    endfunction

    function automatic injector_pkg::header_t expected_header(
        input injector_pkg::flit_t app_id, input int n);
        injector_pkg::header_t h;
        h     = '0;
        h[0]  = task_target[n];
        h[1]  = code_len(n) + 32'd11;
        h[2]  = `INJ_SVC_TASK_ALLOCATION;
        h[3]  = {16'h0000, app_id[7:0], 8'(n)};
        h[4]  = `INJ_MAPPER_ADDRESS;
        h[9]  = task_sizes[n].data_size;
        h[10] = task_sizes[n].text_size;
        h[11] = task_sizes[n].bss_size;
        h[12] = task_sizes[n].entry_point;
        return h;
    endfunction

    // transfers are decided here, half a cycle after the inputs settle.
    always @(negedge clk_i) begin
        if (src_rx_i && src_credit_o) begin
            void'(src_q.pop_front());
        end
        if (noc_rx_i && noc_credit_o) begin
            void'(noc_in_q.pop_front());
        end
        if (noc_tx_o && noc_credit_i) begin
            out_q.push_back(noc_data_o);
        end
    end

    always @(posedge clk_i) begin
        #1;
        lcg_state    = lcg_step(lcg_state);
        noc_credit_i = !stress_en || (lcg_state[17:16] != 2'b00);
        src_rx_i     = (src_q.size() > 0) && (!stress_en || (lcg_state[20:19] != 2'b00));
        src_data_i   = (src_q.size() > 0) ? src_q[0] : '0;
        noc_rx_i     = noc_in_q.size() > 0;
        noc_data_i   = (noc_in_q.size() > 0) ? noc_in_q[0] : '0;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_flit(input string name, input injector_pkg::flit_t exp_val,
                                input injector_pkg::flit_t act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
            err_cnt++;
        end
    endtask

    task automatic compare_header(input string name, input injector_pkg::header_t exp_val,
                                  input injector_pkg::header_t act_val);
        if (act_val !== exp_val) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
            err_cnt++;
        end
    endtask

    task automatic report_failure(input string name, input string what);
        $display("%s: %s", name, what);
        err_cnt++;
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic set_task(input int n, input injector_pkg::flit_t text,
                            input injector_pkg::flit_t data, input injector_pkg::flit_t bss,
                            input injector_pkg::flit_t entry, input injector_pkg::flit_t target);
        task_sizes[n] = '{text_size: text, data_size: data, bss_size: bss, entry_point: entry};
        task_target[n] = target;
    endtask

    // mapper packet with the words queued in pld_q as payload.
    task automatic push_packet(input injector_pkg::flit_t service);
        noc_in_q.push_back(32'h0000_0001);
        noc_in_q.push_back(injector_pkg::flit_t'(11 + pld_q.size()));
        noc_in_q.push_back(service);
        for (int i = 3; i < hdr_words; i++) begin
            noc_in_q.push_back('0);
        end
        foreach (pld_q[i]) begin
            noc_in_q.push_back(pld_q[i]);
        end
        pld_q.delete();
    endtask

    task automatic send_noise(input injector_pkg::flit_t app_id);
        pld_q.push_back(`INJ_KIND_ALLOCATION_REQUEST);
        pld_q.push_back(app_id);
        pld_q.push_back(32'hbad0_0001);
        push_packet(`INJ_SVC_TASK_ALLOCATION);
        // one payload word more than the receiver keeps.
        pld_q.push_back(`INJ_KIND_ALLOCATION_REQUEST);
        pld_q.push_back(app_id);
        for (int i = 2; i < `INJ_MAX_PAYLOAD; i++) begin
            pld_q.push_back(32'hbad0_0000 + i);
        end
        pld_q.push_back(`INJ_KIND_ALLOCATION_REQUEST);  // lands on word 0 if it were stored.
        push_packet(`INJ_SVC_MESSAGE_DELIVERY);
    endtask

    task automatic run_app(input string name, input int ntasks,
                           input injector_pkg::flit_t app_id, input bit noise);
        int unsigned           total;
        int unsigned           base;
        logic                  credit_early;
        logic                  credit_busy;
        injector_pkg::header_t act_hdr;
        total        = 0;
        base         = 0;
        credit_early = 1'b0;
        credit_busy  = 1'b0;
        out_q.delete();
        src_q.push_back(injector_pkg::flit_t'(ntasks));
        while (src_q.size() > 0) @(negedge clk_i);
        for (int n = 0; n < ntasks; n++) begin
            src_q.push_back(task_sizes[n].text_size);
            src_q.push_back(task_sizes[n].data_size);
            src_q.push_back(task_sizes[n].bss_size);
            src_q.push_back(task_sizes[n].entry_point);
            for (int k = 0; k < code_len(n); k++) begin
                src_q.push_back(code_word(app_id, n, k));
            end
            total += hdr_words + code_len(n);
        end
        if (noise) begin
            send_noise(app_id);
            while (noc_in_q.size() > 0) @(negedge clk_i);
            repeat (20) @(negedge clk_i);
            if (out_q.size() != 0) begin
                report_failure(name, "a packet left the DUT before the allocation request");
            end
        end
        pld_q.push_back(`INJ_KIND_ALLOCATION_REQUEST);
        pld_q.push_back(app_id);
        for (int n = 0; n < ntasks; n++) begin
            pld_q.push_back(task_target[n]);
        end
        push_packet(`INJ_SVC_MESSAGE_DELIVERY);
        while (out_q.size() < total) begin
            @(negedge clk_i);
            if (out_q.size() > 0 && noc_credit_o) begin
                credit_busy = 1'b1;
            end
        end
        if (credit_busy) begin
            report_failure(name, "noc_credit_o was high while the tasks were being sent");
        end
        for (int n = 0; n < ntasks; n++) begin
            for (int i = 0; i < hdr_words; i++) begin
                act_hdr[i] = out_q[base + i];
            end
            compare_header(name, expected_header(app_id, n), act_hdr);
            base += hdr_words;
            for (int k = 0; k < code_len(n); k++) begin
                compare_flit(name, code_word(app_id, n, k), out_q[base + k]);
            end
            base += code_len(n);
        end
        repeat (20) begin
            @(negedge clk_i);
            if (src_credit_o) credit_early = 1'b1;
        end
        if (credit_early) begin
            report_failure(name, "src_credit_o rose before the mapping complete message");
        end
        if (out_q.size() != total) begin
            report_failure(name, "the DUT sent more flits than the tasks need");
        end
        pld_q.push_back(`INJ_KIND_MAPPING_COMPLETE);
        pld_q.push_back(app_id);
        push_packet(`INJ_SVC_MESSAGE_DELIVERY);
        while (!src_credit_o) @(negedge clk_i);
        if (src_q.size() != 0) begin
            report_failure(name, "source words were left over after the application");
        end
    endtask

    task automatic set_three_tasks();
        set_task(0, 32'd16, 32'd8, 32'd32, 32'h0000_0200, 32'h0000_0102);
        set_task(1, 32'd28, 32'd4, 32'd0, 32'h0000_0310, 32'h0000_0201);
        set_task(2, 32'd8, 32'd12, 32'd64, 32'h0000_0040, 32'h0000_0303);
    endtask

    task automatic test_single_task();
        int unsigned errs;
        errs = err_cnt;
        set_task(0, 32'd24, 32'd8, 32'd16, 32'h0000_0100, 32'h0000_0101);
        run_app("single_task", 1, 32'h0000_0005, 1'b0);
        report_test("single_task", errs);
    endtask

    task automatic test_three_tasks();
        int unsigned errs;
        errs = err_cnt;
        set_three_tasks();
        run_app("three_tasks", 3, 32'h0000_0012, 1'b0);
        ref_q = out_q;
        report_test("three_tasks", errs);
    endtask

    task automatic test_back_pressure();
        int unsigned errs;
        errs      = err_cnt;
        stress_en = 1'b1;
        run_app("back_pressure", 3, 32'h0000_0012, 1'b0);
        stress_en = 1'b0;
        if (out_q.size() != ref_q.size()) begin
            report_failure("back_pressure", "flit count differs from the unstressed run");
        end else begin
            foreach (ref_q[i]) begin
                compare_flit("back_pressure", ref_q[i], out_q[i]);
            end
        end
        report_test("back_pressure", errs);
    endtask

    task automatic test_ignored_traffic();
        int unsigned errs;
        errs = err_cnt;
        set_task(0, 32'd12, 32'd4, 32'd8, 32'h0000_0080, 32'h0000_0203);
        set_task(1, 32'd20, 32'd0, 32'd4, 32'h0000_0090, 32'h0000_0302);
        run_app("ignored_traffic", 2, 32'h0000_0033, 1'b1);
        report_test("ignored_traffic", errs);
    endtask

    task automatic test_completion();
        int unsigned errs;
        errs = err_cnt;
        set_three_tasks();
        run_app("completion", 2, 32'h0000_0021, 1'b0);
        set_task(0, 32'd32, 32'd16, 32'd0, 32'h0000_0400, 32'h0000_0110);
        run_app("completion", 1, 32'h0000_0022, 1'b0);
        report_test("completion", errs);
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        src_rx_i     = 1'b0;
        src_data_i   = '0;
        noc_credit_i = 1'b0;
        noc_rx_i     = 1'b0;
        noc_data_i   = '0;
        lcg_state    = 32'd8379;
        stress_en    = 1'b0;
        cycle_cnt    = 0;
        err_cnt      = 0;
        test_cnt     = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        test_single_task();
        test_three_tasks();
        test_back_pressure();
        test_ignored_traffic();
        test_completion();
        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/task_injector.sv
`timescale 1ns/100ps

module task_injector (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                src_rx_i,
    input  injector_pkg::flit_t src_data_i,
    output logic                src_credit_o,
    output logic                noc_tx_o,
    input  logic                noc_credit_i,
    output injector_pkg::flit_t noc_data_o,
    input  logic                noc_rx_i,
    output logic                noc_credit_o,
    input  injector_pkg::flit_t noc_data_i
);

    injector_pkg::rx_event_t rx_event;
    injector_pkg::payload_t  payload;
    injector_pkg::header_t   header;
    logic                    listen;
    logic                    send_start;
    logic                    send_done;
    logic                    ctrl_src_credit;
    logic                    send_src_credit;

    packet_receiver u_receiver (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .listen_i     (listen),
        .noc_rx_i     (noc_rx_i),
        .noc_data_i   (noc_data_i),
        .noc_credit_o (noc_credit_o),
        .rx_event_o   (rx_event),
        .payload_o    (payload)
    );

    packet_sender u_sender (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .send_start_i (send_start),
        .header_i     (header),
        .noc_credit_i (noc_credit_i),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .noc_tx_o     (noc_tx_o),
        .noc_data_o   (noc_data_o),
        .src_credit_o (send_src_credit),
        .send_done_o  (send_done)
    );

    injector_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .rx_event_i   (rx_event),
        .payload_i    (payload),
        .send_done_i  (send_done),
        .src_credit_o (ctrl_src_credit),
        .listen_o     (listen),
        .send_start_o (send_start),
        .header_o     (header)
    );

    // sizes and code words never overlap on the source port.
    assign src_credit_o = ctrl_src_credit | send_src_credit;

endmodule

//--- design/injector_ctrl.sv
`timescale 1ns/100ps
`include "injector_cfg.svh"

module injector_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    src_rx_i,
    input  injector_pkg::flit_t     src_data_i,
    input  injector_pkg::rx_event_t rx_event_i,
    input  injector_pkg::payload_t  payload_i,
    input  logic                    send_done_i,
    output logic                    src_credit_o,
    output logic                    listen_o,
    output logic                    send_start_o,
    output injector_pkg::header_t   header_o
);

    typedef enum logic [3:0] {
        ctrl_idle,
        ctrl_wait_alloc,
        ctrl_text_size,
        ctrl_data_size,
        ctrl_bss_size,
        ctrl_entry,
        ctrl_send,
        ctrl_next,
        ctrl_wait_complete
    } ctrl_state_t;

    ctrl_state_t               state_q;
    ctrl_state_t               state_d;
    logic [7:0]                task_cnt_q;
    logic [7:0]                task_idx_q;
    logic [7:0]                target_sel;
    injector_pkg::flit_t       app_id_q;
    injector_pkg::flit_t       code_words;
    injector_pkg::task_sizes_t sizes_q;
    logic                      credit_q;
    logic                      start_q;
    logic                      accept;
    logic                      collecting_d;

    assign accept = src_rx_i & credit_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrl_idle:          if (accept) state_d = ctrl_wait_alloc;
            ctrl_wait_alloc:    if (rx_event_i.alloc_valid) state_d = ctrl_text_size;
            ctrl_text_size:     if (accept) state_d = ctrl_data_size;
            ctrl_data_size:     if (accept) state_d = ctrl_bss_size;
            ctrl_bss_size:      if (accept) state_d = ctrl_entry;
            ctrl_entry:         if (accept) state_d = ctrl_send;
            ctrl_send:          if (send_done_i) state_d = ctrl_next;
            ctrl_next: begin
                state_d = (task_idx_q == task_cnt_q - 8'd1) ? ctrl_wait_complete
                                                            : ctrl_text_size;
            end
            ctrl_wait_complete: if (rx_event_i.complete_valid) state_d = ctrl_idle;
            default:            state_d = ctrl_idle;
        endcase
    end

    // the source is open in idle for the task count and in the size states.
    assign collecting_d = state_d inside {ctrl_idle, ctrl_text_size, ctrl_data_size,
                                          ctrl_bss_size, ctrl_entry};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ctrl_idle;
            credit_q   <= 1'b0;
            start_q    <= 1'b0;
            task_cnt_q <= '0;
            task_idx_q <= '0;
        end else begin
            state_q  <= state_d;
            credit_q <= collecting_d;
            start_q  <= (state_q == ctrl_entry) & accept;  // header is complete next cycle.
            if (state_q == ctrl_idle && accept) begin
                task_cnt_q <= src_data_i[7:0];
                task_idx_q <= '0;
            end else if (state_q == ctrl_next && state_d == ctrl_text_size) begin
                task_idx_q <= task_idx_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ctrl_wait_alloc && rx_event_i.alloc_valid) begin
            app_id_q <= rx_event_i.app_id;
        end
        if (accept) begin
            case (state_q)
                ctrl_text_size: sizes_q.text_size   <= src_data_i;
                ctrl_data_size: sizes_q.data_size   <= src_data_i;
                ctrl_bss_size:  sizes_q.bss_size    <= src_data_i;
                ctrl_entry:     sizes_q.entry_point <= src_data_i;
                default: ;
            endcase
        end
    end

    assign code_words = (sizes_q.text_size + sizes_q.data_size) >> 2;  // sizes are in bytes.
    assign target_sel = task_idx_q + 8'(injector_pkg::pld_targets);

    always_comb begin
        header_o = '0;
        header_o[injector_pkg::hdr_target] =
            payload_i[target_sel[injector_pkg::payload_idx_w-1:0]];
        header_o[injector_pkg::hdr_size] =
            code_words + injector_pkg::flit_t'(injector_pkg::hdr_overhead);
        header_o[injector_pkg::hdr_service] =
            injector_pkg::flit_t'(`INJ_SVC_TASK_ALLOCATION);
        header_o[injector_pkg::hdr_task_id] =
            {{(`INJ_FLIT_SIZE - 16){1'b0}}, app_id_q[7:0], task_idx_q};
        header_o[injector_pkg::hdr_mapper] = injector_pkg::flit_t'(`INJ_MAPPER_ADDRESS);
        header_o[injector_pkg::hdr_data_size] = sizes_q.data_size;
        header_o[injector_pkg::hdr_text_size] = sizes_q.text_size;
        header_o[injector_pkg::hdr_bss_size]  = sizes_q.bss_size;
        header_o[injector_pkg::hdr_entry]     = sizes_q.entry_point;
    end

    assign src_credit_o = credit_q;
    assign listen_o     = state_q inside {ctrl_wait_alloc, ctrl_wait_complete};
    assign send_start_o = start_q;

    // a task count of zero or a missed last task would break the target lookup.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q inside {ctrl_text_size, ctrl_data_size, ctrl_bss_size, ctrl_entry,
                         ctrl_send, ctrl_next}) |-> task_idx_q < task_cnt_q);

endmodule

//--- design/packet_sender.sv
`timescale 1ns/100ps
`include "injector_cfg.svh"

module packet_sender (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  send_start_i,
    input  injector_pkg::header_t header_i,
    input  logic                  noc_credit_i,
    input  logic                  src_rx_i,
    input  injector_pkg::flit_t   src_data_i,
    output logic                  noc_tx_o,
    output injector_pkg::flit_t   noc_data_o,
    output logic                  src_credit_o,
    output logic                  send_done_o
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_header,
        tx_code
    } tx_state_t;

    tx_state_t             state_q;
    injector_pkg::header_t header_q;
    injector_pkg::flit_t   code_len_q;  // source words after the header.
    injector_pkg::flit_t   code_cnt_q;
    logic                  done_q;
    logic                  hdr_last;
    logic                  code_xfer;
    logic                  code_last;

    logic [injector_pkg::header_idx_w-1:0] hdr_idx_q;

    assign hdr_last  = (state_q == tx_header) && noc_credit_i &&
                       (hdr_idx_q == `INJ_HEADER_SIZE - 1);
    assign code_xfer = (state_q == tx_code) && src_rx_i && noc_credit_i;
    assign code_last = code_xfer && (code_cnt_q == code_len_q - 1'b1);

    always_ff @(posedge clk_i) begin
        if (send_start_i) begin
            header_q   <= header_i;
            code_len_q <= header_i[injector_pkg::hdr_size] -
                          injector_pkg::flit_t'(injector_pkg::hdr_overhead);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= tx_idle;
            hdr_idx_q  <= '0;
            code_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                tx_idle: begin
                    if (send_start_i) begin
                        state_q    <= tx_header;
                        hdr_idx_q  <= '0;
                        code_cnt_q <= '0;
                    end
                end
                tx_header: begin
                    if (hdr_last) begin
                        if (code_len_q == '0) begin  // task without code.
                            state_q <= tx_idle;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= tx_code;
                        end
                    end else if (noc_credit_i) begin
                        hdr_idx_q <= hdr_idx_q + 1'b1;
                    end
                end
                tx_code: begin
                    if (code_last) begin
                        state_q <= tx_idle;
                        done_q  <= 1'b1;
                    end else if (code_xfer) begin
                        code_cnt_q <= code_cnt_q + 1'b1;
                    end
                end
                default: state_q <= tx_idle;
            endcase
        end
    end

    // code words pass straight from the source to the NoC.
    assign noc_tx_o     = (state_q == tx_header) | ((state_q == tx_code) & src_rx_i);
    assign noc_data_o   = (state_q == tx_header) ? header_q[hdr_idx_q] : src_data_i;
    assign src_credit_o = (state_q == tx_code) & noc_credit_i;
    assign send_done_o  = done_q;

    // the controller waits for done before it starts the next task.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        send_start_i |-> state_q == tx_idle);

endmodule

//--- design/packet_receiver.sv
`timescale 1ns/100ps
`include "injector_cfg.svh"

module packet_receiver (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    listen_i,
    input  logic                    noc_rx_i,
    input  injector_pkg::flit_t     noc_data_i,
    output logic                    noc_credit_o,
    output injector_pkg::rx_event_t rx_event_o,
    output injector_pkg::payload_t  payload_o
);

    // largest size field whose payload still fits the table.
    localparam injector_pkg::flit_t max_size =
        injector_pkg::flit_t'(injector_pkg::hdr_overhead + `INJ_MAX_PAYLOAD);

    typedef enum logic [1:0] {
        rx_header,
        rx_payload,
        rx_drain
    } rx_state_t;

    rx_state_t              state_q;
    injector_pkg::flit_t    pos_q;  // flit position inside the packet.
    injector_pkg::flit_t    payload_pos;
    injector_pkg::header_t  header_q;
    injector_pkg::payload_t payload_q;
    logic                   done_q;
    logic                   xfer;
    logic                   last_flit;
    logic                   oversize;
    logic                   is_delivery;
    logic                   has_payload;

    logic [injector_pkg::header_idx_w-1:0]  header_idx;
    logic [injector_pkg::payload_idx_w-1:0] payload_idx;

    assign noc_credit_o = listen_i | (state_q == rx_drain);
    assign xfer         = noc_rx_i & noc_credit_o;

    assign oversize = noc_data_i > max_size;  // valid while pos_q is the size flit.

    // the size field is stored long before the shortest packet ends.
    assign last_flit = xfer && (pos_q >= injector_pkg::flit_t'(`INJ_HEADER_SIZE - 1)) &&
                       (pos_q == header_q[injector_pkg::hdr_size] + 1'b1);

    assign payload_pos = pos_q - injector_pkg::flit_t'(`INJ_HEADER_SIZE);
    assign header_idx  = pos_q[injector_pkg::header_idx_w-1:0];
    assign payload_idx = payload_pos[injector_pkg::payload_idx_w-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= rx_header;
            pos_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (last_flit) begin
                pos_q   <= '0;
                state_q <= rx_header;
                done_q  <= (state_q != rx_drain);  // drained packets raise no event.
            end else if (xfer) begin
                pos_q <= pos_q + 1'b1;
                if (state_q == rx_header) begin
                    if (pos_q == injector_pkg::hdr_size && oversize) begin
                        state_q <= rx_drain;
                    end else if (pos_q == `INJ_HEADER_SIZE - 1) begin
                        state_q <= rx_payload;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && state_q == rx_header) begin
            header_q[header_idx] <= noc_data_i;
        end
        if (xfer && state_q == rx_payload) begin
            payload_q[payload_idx] <= noc_data_i;
        end
    end

    assign is_delivery = header_q[injector_pkg::hdr_service] ==
                         injector_pkg::flit_t'(`INJ_SVC_MESSAGE_DELIVERY);
    assign has_payload = header_q[injector_pkg::hdr_size] >
                         injector_pkg::flit_t'(injector_pkg::hdr_overhead);

    assign rx_event_o.alloc_valid = done_q & is_delivery & has_payload &
        (payload_q[injector_pkg::pld_kind] ==
         injector_pkg::flit_t'(`INJ_KIND_ALLOCATION_REQUEST));
    assign rx_event_o.complete_valid = done_q & is_delivery & has_payload &
        (payload_q[injector_pkg::pld_kind] ==
         injector_pkg::flit_t'(`INJ_KIND_MAPPING_COMPLETE));
    assign rx_event_o.app_id = payload_q[injector_pkg::pld_app_id];

    assign payload_o = payload_q;

    // the drain decision at the size flit keeps every store in range.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (xfer && state_q == rx_payload) |->
            payload_pos < injector_pkg::flit_t'(`INJ_MAX_PAYLOAD));

endmodule

//--- design/injector_pkg.sv
`include "injector_cfg.svh"

package injector_pkg;

    // one NoC flit or one source word.
    typedef logic [`INJ_FLIT_SIZE-1:0] flit_t;

    typedef flit_t [`INJ_HEADER_SIZE-1:0] header_t;

    typedef flit_t [`INJ_MAX_PAYLOAD-1:0] payload_t;

    // index widths for the header and the payload table.
    localparam int unsigned header_idx_w  = $clog2(`INJ_HEADER_SIZE);
    localparam int unsigned payload_idx_w = $clog2(`INJ_MAX_PAYLOAD);

    // header flits counted by the size field.
    localparam int unsigned hdr_overhead = `INJ_HEADER_SIZE - 2;

    localparam int unsigned hdr_target    = 0;
    localparam int unsigned hdr_size      = 1;
    localparam int unsigned hdr_service   = 2;
    localparam int unsigned hdr_task_id   = 3;  // app id and task index.
    localparam int unsigned hdr_mapper    = 4;
    localparam int unsigned hdr_data_size = 9;
    localparam int unsigned hdr_text_size = 10;
    localparam int unsigned hdr_bss_size  = 11;
    localparam int unsigned hdr_entry     = 12;

    // delivery payload layout.
    localparam int unsigned pld_kind    = 0;
    localparam int unsigned pld_app_id  = 1;
    localparam int unsigned pld_targets = 2;  // first task target address.

    // sizes sent by the source ahead of each task's code.
    typedef struct packed {
        flit_t text_size;
        flit_t data_size;
        flit_t bss_size;
        flit_t entry_point;
    } task_sizes_t;

    // decoded mapper message, the valids are one-cycle pulses.
    typedef struct packed {
        logic  alloc_valid;
        logic  complete_valid;
        flit_t app_id;
    } rx_event_t;

endpackage

//--- design/injector_cfg.svh
`ifndef INJECTOR_CFG_SVH
`define INJECTOR_CFG_SVH

// NoC word width in bits.
`define INJ_FLIT_SIZE 32

// flits in every packet header.
`define INJ_HEADER_SIZE 13

// payload words kept by the receiver, longer packets are drained.
`define INJ_MAX_PAYLOAD 16

`define INJ_MAPPER_ADDRESS 0

// services carried in header flit 2.
`define INJ_SVC_MESSAGE_DELIVERY 'h00000001
`define INJ_SVC_TASK_ALLOCATION  'h00000040

// message kinds carried in payload word 0 of a delivery.
`define INJ_KIND_ALLOCATION_REQUEST 'h00000240
`define INJ_KIND_MAPPING_COMPLETE   'h00000241

`endif
